// ==== axi_xbar_rd.f ====
+incdir+design
design/axi_pkg.sv
design/xbar_pkg.sv
design/ar_channel_router.sv
design/default_slave.sv
design/r_channel_router.sv
design/axi_xbar_rd.sv
testbench/xbar_checker.sv
testbench/tb_axi_xbar_rd.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_xbar_rd -f axi_xbar_rd.f -o sim_axi_xbar_rd
./obj_dir/sim_axi_xbar_rd > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "ALL TESTS PASSED" sim.log

// ==== testbench/tb_axi_xbar_rd.sv ====
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module tb_axi_xbar_rd
  import axi_pkg::*;
  import xbar_pkg::*;
;

  localparam int N_TXN = 20;  // Per master
  localparam time LIMIT = 2 * N_TXN * 8 * 40 * 4ns;

  logic        clk;
  logic        rstn;
  ar_mst_t     m_ar [2];
  r_mst_t      m_r [2];
  logic [1:0]  m_arvalid, m_arready, m_rvalid, m_rready;
  ar_slv_t     s_ar [2];
  r_slv_t      s_r [2];
  logic [1:0]  s_arvalid, s_arready, s_rvalid, s_rready;
  logic [31:0] rng_state;
  int          errors, bursts;

  axi_xbar_rd u_axi_xbar_rd (
    .clk(clk), .rstn(rstn),
    .m0_ar(m_ar[0]), .m0_arvalid(m_arvalid[0]), .m0_arready(m_arready[0]),
    .m0_r(m_r[0]), .m0_rvalid(m_rvalid[0]), .m0_rready(m_rready[0]),
    .m1_ar(m_ar[1]), .m1_arvalid(m_arvalid[1]), .m1_arready(m_arready[1]),
    .m1_r(m_r[1]), .m1_rvalid(m_rvalid[1]), .m1_rready(m_rready[1]),
    .s0_ar(s_ar[0]), .s0_arvalid(s_arvalid[0]), .s0_arready(s_arready[0]),
    .s0_r(s_r[0]), .s0_rvalid(s_rvalid[0]), .s0_rready(s_rready[0]),
    .s1_ar(s_ar[1]), .s1_arvalid(s_arvalid[1]), .s1_arready(s_arready[1]),
    .s1_r(s_r[1]), .s1_rvalid(s_rvalid[1]), .s1_rready(s_rready[1])
  );

  xbar_checker u_checker (
    .clk(clk), .rstn(rstn),
    .m0_ar(m_ar[0]), .m0_arvalid(m_arvalid[0]), .m0_arready(m_arready[0]),
    .m0_r(m_r[0]), .m0_rvalid(m_rvalid[0]), .m0_rready(m_rready[0]),
    .m1_ar(m_ar[1]), .m1_arvalid(m_arvalid[1]), .m1_arready(m_arready[1]),
    .m1_r(m_r[1]), .m1_rvalid(m_rvalid[1]), .m1_rready(m_rready[1]),
    .s0_ar(s_ar[0]), .s0_arvalid(s_arvalid[0]), .s0_arready(s_arready[0]),
    .s0_r(s_r[0]), .s0_rvalid(s_rvalid[0]), .s0_rready(s_rready[0]),
    .s1_ar(s_ar[1]), .s1_arvalid(s_arvalid[1]), .s1_arready(s_arready[1]),
    .s1_r(s_r[1]), .s1_rvalid(s_rvalid[1]), .s1_rready(s_rready[1]),
    .errors(errors), .bursts(bursts)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  always #2 clk = ~clk;

  // Random rready gaps, roughly one cycle in four
  always @(posedge clk) begin
    #1;
    m_rready[0] = (next_rand() % 4) != 0;
    m_rready[1] = (next_rand() % 4) != 0;
  end

  task automatic drive_master(int m);
    logic [31:0] pick;
    for (int t = 0; t < N_TXN; t++) begin
      pick = next_rand() % 8;
      m_ar[m].id    = axi_id_t'(next_rand());
      m_ar[m].len   = axi_len_t'(next_rand() % 8);
      m_ar[m].size  = 3'd2;
      m_ar[m].burst = 2'b01;
      if (pick < 3) m_ar[m].addr = `S0_BASE + (next_rand() & 32'hfffc);
      else if (pick < 6) m_ar[m].addr = `S1_BASE + (next_rand() & 32'hfffc);
      else m_ar[m].addr = 32'h8000_0000 | (next_rand() & 32'hfffc);  // Unmapped
      m_arvalid[m] = 1'b1;
      do @(negedge clk); while (!m_arready[m]);
      @(posedge clk);
      #1;
      m_arvalid[m] = 1'b0;
      repeat (next_rand() % 4) @(posedge clk);
    end
  endtask

  task automatic serve_slave(int k);
    ar_slv_t     a;
    logic [31:0] addr;
    forever begin
      @(negedge clk);
      if (rstn && s_arvalid[k]) begin
        a = s_ar[k];
        repeat ((next_rand() % 4) + 1) @(posedge clk);
        #1;
        s_arready[k] = 1'b1;
        @(posedge clk);
        #1;
        s_arready[k] = 1'b0;
        for (int b = 0; b <= int'(a.len); b++) begin
          addr = a.addr + 32'(4 * b);
          s_r[k] = '{id: a.id, data: {8'(k), addr[23:0]}, resp: RESP_OKAY,
                     last: (b == int'(a.len))};
          s_rvalid[k] = 1'b1;
          do @(negedge clk); while (!s_rready[k]);
          @(posedge clk);
          #1;
        end
        s_rvalid[k] = 1'b0;
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    rng_state = 32'd73;
    m_ar      = '{'0, '0};
    s_r       = '{'0, '0};
    m_arvalid = '0;
    m_rready  = '0;
    s_arready = '0;
    s_rvalid  = '0;
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    fork
      serve_slave(0);
      serve_slave(1);
    join_none
    repeat (2) @(posedge clk);
    #1;
    // Both masters start in the same cycle
    fork
      drive_master(0);
      drive_master(1);
    join
    wait (bursts == 2 * N_TXN);
    repeat (4) @(posedge clk);
    $display("checks done: %0d bursts, %0d errors", bursts, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(LIMIT);
    $display("timeout, only %0d of %0d bursts completed, %0d errors",
             bursts, 2 * N_TXN, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== testbench/xbar_checker.sv ====
`timescale 1ns/1ps

module xbar_checker
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  ar_mst_t m0_ar,
  input  logic    m0_arvalid,
  input  logic    m0_arready,
  input  r_mst_t  m0_r,
  input  logic    m0_rvalid,
  input  logic    m0_rready,
  input  ar_mst_t m1_ar,
  input  logic    m1_arvalid,
  input  logic    m1_arready,
  input  r_mst_t  m1_r,
  input  logic    m1_rvalid,
  input  logic    m1_rready,
  input  ar_slv_t s0_ar,
  input  logic    s0_arvalid,
  input  logic    s0_arready,
  input  r_slv_t  s0_r,
  input  logic    s0_rvalid,
  input  logic    s0_rready,
  input  ar_slv_t s1_ar,
  input  logic    s1_arvalid,
  input  logic    s1_arready,
  input  r_slv_t  s1_r,
  input  logic    s1_rvalid,
  input  logic    s1_rready,
  output int      errors,
  output int      bursts
);

  ar_mst_t exp_ar [2];
  logic    pend [2];
  int      beat_cnt [2];
  logic    s_open [2];
  logic    prev_av0, prev_av1;
  int      since_rst;

  // Expected beat from the address map and the data rule of the slave models
  function automatic r_mst_t expected_beat(ar_mst_t ar, int beat);
    r_mst_t    e;
    axi_addr_t a;
    a      = ar.addr + axi_addr_t'(4 * beat);
    e.id   = ar.id;
    e.last = (beat == int'(ar.len));
    case (decode_slave(ar.addr))
      SEL_S0: begin
        e.data = {8'h00, a[23:0]};
        e.resp = RESP_OKAY;
      end
      SEL_S1: begin
        e.data = {8'h01, a[23:0]};
        e.resp = RESP_OKAY;
      end
      default: begin
        e.data = '0;
        e.resp = RESP_DECERR;
      end
    endcase
    return e;
  endfunction

  task automatic compare_hex(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // Slave-side request is the master request with its tag above the ID
  task automatic compare_ar(int k, ar_slv_t got, mst_tag_t tag, ar_mst_t ar);
    compare_hex($sformatf("s%0d_ar.id", k), 32'(got.id), 32'({tag, ar.id}));
    compare_hex($sformatf("s%0d_ar.addr", k), got.addr, ar.addr);
    compare_hex($sformatf("s%0d_ar.len", k), 32'(got.len), 32'(ar.len));
  endtask

  task automatic watch_master(int m, logic av, logic ardy, ar_mst_t ar,
                              logic rv, logic rrdy, r_mst_t r);
    r_mst_t e;
    if (rv && rrdy) begin
      if (!pend[m]) begin
        $display("master %0d got a read beat with no burst open at %0t", m, $time);
        errors++;
      end else begin
        e = expected_beat(exp_ar[m], beat_cnt[m]);
        compare_hex($sformatf("m%0d_r.data", m), r.data, e.data);
        compare_hex($sformatf("m%0d_r.resp", m), 32'(r.resp), 32'(e.resp));
        compare_hex($sformatf("m%0d_r.id", m), 32'(r.id), 32'(e.id));
        compare_hex($sformatf("m%0d_r.last", m), 32'(r.last), 32'(e.last));
        beat_cnt[m]++;
        if (e.last) begin
          pend[m] = 1'b0;
          bursts++;
        end
      end
    end
    if (av && ardy) begin
      if (pend[m]) begin
        $display("master %0d had a second AR accepted while its burst was open", m);
        errors++;
      end
      pend[m]     = 1'b1;
      exp_ar[m]   = ar;
      beat_cnt[m] = 0;
    end
  endtask

  task automatic watch_slave(int k, logic av, logic ardy, ar_slv_t ar,
                             logic rv, logic rrdy, logic last);
    if (av && s_open[k]) begin
      $display("slave %0d saw arvalid while its burst was open at %0t", k, $time);
      errors++;
    end
    if (rv && rrdy && last) s_open[k] = 1'b0;
    if (av && ardy) begin
      s_open[k] = 1'b1;
      if (m0_arvalid && m0_arready) begin
        compare_ar(k, ar, MST0_TAG, m0_ar);
      end else if (m1_arvalid && m1_arready) begin
        compare_ar(k, ar, MST1_TAG, m1_ar);
      end else begin
        $display("slave %0d accepted an AR that no master issued at %0t", k, $time);
        errors++;
      end
    end
  endtask

  initial begin
    errors    = 0;
    bursts    = 0;
    pend      = '{1'b0, 1'b0};
    s_open    = '{1'b0, 1'b0};
    beat_cnt  = '{0, 0};
    prev_av0  = 1'b0;
    prev_av1  = 1'b0;
    since_rst = 0;
  end

  // Negedge sampling, between input changes and the handshake edge
  always @(negedge clk) begin
    if (!rstn || since_rst <= 1) begin
      if ({m0_arready, m1_arready, m0_rvalid, m1_rvalid,
           s0_arvalid, s1_arvalid, s0_rready, s1_rready} !== '0) begin
        $display("a valid or ready output was high around reset at %0t", $time);
        errors++;
      end
    end
    if (!rstn) begin
      since_rst = 0;
    end else begin
      since_rst++;
      // Both requests arrive together with M0 free, M0 must win
      if (m0_arvalid && m1_arvalid && !prev_av0 && !prev_av1 && !pend[0]) begin
        if (m1_arready) begin
          $display("M1 was granted over M0 in a free cycle at %0t", $time);
          errors++;
        end
        if ((s0_arvalid && s0_ar.id !== {MST0_TAG, m0_ar.id}) ||
            (s1_arvalid && s1_ar.id !== {MST0_TAG, m0_ar.id})) begin
          $display("a slave saw a request other than M0's in a free cycle at %0t", $time);
          errors++;
        end
      end
      watch_master(0, m0_arvalid, m0_arready, m0_ar, m0_rvalid, m0_rready, m0_r);
      watch_master(1, m1_arvalid, m1_arready, m1_ar, m1_rvalid, m1_rready, m1_r);
      watch_slave(0, s0_arvalid, s0_arready, s0_ar, s0_rvalid, s0_rready, s0_r.last);
      watch_slave(1, s1_arvalid, s1_arready, s1_ar, s1_rvalid, s1_rready, s1_r.last);
    end
    prev_av0 = m0_arvalid;
    prev_av1 = m1_arvalid;
  end

endmodule

// ==== design/axi_xbar_rd.sv ====
`timescale 1ns/1ps

module axi_xbar_rd
  import axi_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  ar_mst_t m0_ar,
  input  logic    m0_arvalid,
  output logic    m0_arready,
  output r_mst_t  m0_r,
  output logic    m0_rvalid,
  input  logic    m0_rready,
  input  ar_mst_t m1_ar,
  input  logic    m1_arvalid,
  output logic    m1_arready,
  output r_mst_t  m1_r,
  output logic    m1_rvalid,
  input  logic    m1_rready,
  output ar_slv_t s0_ar,
  output logic    s0_arvalid,
  input  logic    s0_arready,
  input  r_slv_t  s0_r,
  input  logic    s0_rvalid,
  output logic    s0_rready,
  output ar_slv_t s1_ar,
  output logic    s1_arvalid,
  input  logic    s1_arready,
  input  r_slv_t  s1_r,
  input  logic    s1_rvalid,
  output logic    s1_rready
);

  ar_slv_t sd_ar;
  r_slv_t  sd_r;
  logic    sd_arvalid, sd_arready;
  logic    sd_rvalid, sd_rready;
  logic    m0_rdone, m1_rdone;
  logic    s0_rdone, s1_rdone, sd_rdone;

  // Final beat accepted on each side
  assign m0_rdone = m0_rvalid & m0_rready & m0_r.last;
  assign m1_rdone = m1_rvalid & m1_rready & m1_r.last;
  assign s0_rdone = s0_rvalid & s0_rready & s0_r.last;
  assign s1_rdone = s1_rvalid & s1_rready & s1_r.last;
  assign sd_rdone = sd_rvalid & sd_rready & sd_r.last;

  ar_channel_router u_ar_router (
    .clk       (clk),
    .rstn      (rstn),
    .m0_ar     (m0_ar),
    .m1_ar     (m1_ar),
    .m0_arvalid(m0_arvalid),
    .m1_arvalid(m1_arvalid),
    .m0_arready(m0_arready),
    .m1_arready(m1_arready),
    .s0_ar     (s0_ar),
    .s1_ar     (s1_ar),
    .sd_ar     (sd_ar),
    .s0_arvalid(s0_arvalid),
    .s1_arvalid(s1_arvalid),
    .sd_arvalid(sd_arvalid),
    .s0_arready(s0_arready),
    .s1_arready(s1_arready),
    .sd_arready(sd_arready),
    .m0_rdone  (m0_rdone),
    .m1_rdone  (m1_rdone),
    .s0_rdone  (s0_rdone),
    .s1_rdone  (s1_rdone),
    .sd_rdone  (sd_rdone)
  );

  default_slave u_default_slave (
    .clk    (clk),
    .rstn   (rstn),
    .ar     (sd_ar),
    .arvalid(sd_arvalid),
    .arready(sd_arready),
    .r      (sd_r),
    .rvalid (sd_rvalid),
    .rready (sd_rready)
  );

  r_channel_router u_r_router (
    .clk      (clk),
    .rstn     (rstn),
    .s0_r     (s0_r),
    .s1_r     (s1_r),
    .sd_r     (sd_r),
    .s0_rvalid(s0_rvalid),
    .s1_rvalid(s1_rvalid),
    .sd_rvalid(sd_rvalid),
    .s0_rready(s0_rready),
    .s1_rready(s1_rready),
    .sd_rready(sd_rready),
    .m0_r     (m0_r),
    .m1_r     (m1_r),
    .m0_rvalid(m0_rvalid),
    .m1_rvalid(m1_rvalid),
    .m0_rready(m0_rready),
    .m1_rready(m1_rready)
  );

endmodule

// ==== design/r_channel_router.sv ====
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module r_channel_router
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  logic   clk,
  input  logic   rstn,
  input  r_slv_t s0_r,
  input  r_slv_t s1_r,
  input  r_slv_t sd_r,
  input  logic   s0_rvalid,
  input  logic   s1_rvalid,
  input  logic   sd_rvalid,
  output logic   s0_rready,
  output logic   s1_rready,
  output logic   sd_rready,
  output r_mst_t m0_r,
  output r_mst_t m1_r,
  output logic   m0_rvalid,
  output logic   m1_rvalid,
  input  logic   m0_rready,
  input  logic   m1_rready
);

  typedef enum logic [1:0] {
    SRC_IDLE,
    SRC_S0,
    SRC_S1,
    SRC_DEF
  } src_t;

  src_t     src;   // Slave holding the R path
  src_t     pick;
  src_t     cur;
  r_slv_t   sel_r;
  r_mst_t   beat;
  logic     sel_valid;
  logic     sel_ready;
  mst_tag_t tag;

  always_comb begin
    if (s0_rvalid) pick = SRC_S0;
    else if (s1_rvalid) pick = SRC_S1;
    else if (sd_rvalid) pick = SRC_DEF;
    else pick = SRC_IDLE;
  end

  assign cur = (src == SRC_IDLE) ? pick : src;

  always_comb begin
    sel_r     = '0;
    sel_valid = 1'b0;
    case (cur)
      SRC_S0: begin
        sel_r     = s0_r;
        sel_valid = s0_rvalid;
      end
      SRC_S1: begin
        sel_r     = s1_r;
        sel_valid = s1_rvalid;
      end
      SRC_DEF: begin
        sel_r     = sd_r;
        sel_valid = sd_rvalid;
      end
      default: ;
    endcase
  end

  // Tag sits above the master ID
  assign tag  = sel_r.id[`AXI_IDS_BITS-1 -: `AXI_TAG_BITS];
  assign beat = '{id: sel_r.id[`AXI_ID_BITS-1:0], data: sel_r.data,
                  resp: sel_r.resp, last: sel_r.last};

  assign m0_r      = beat;
  assign m1_r      = beat;
  assign m0_rvalid = sel_valid & (tag == MST0_TAG);
  assign m1_rvalid = sel_valid & (tag == MST1_TAG);
  assign sel_ready = (tag == MST0_TAG) ? m0_rready : m1_rready;

  assign s0_rready = (cur == SRC_S0) & sel_ready;
  assign s1_rready = (cur == SRC_S1) & sel_ready;
  assign sd_rready = (cur == SRC_DEF) & sel_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      src <= SRC_IDLE;
    end else if (sel_valid && sel_ready && sel_r.last) begin
      src <= SRC_IDLE;  // Burst complete
    end else begin
      src <= cur;
    end
  end

  a_one_master_valid: assert property (@(posedge clk) disable iff (!rstn)
    !(m0_rvalid && m1_rvalid));

  // No other burst slips in after a non-final M0 beat
  a_no_interleave: assert property (@(posedge clk) disable iff (!rstn)
    m0_rvalid && m0_rready && !m0_r.last |=> !m1_rvalid);

endmodule

// ==== design/default_slave.sv ====
`timescale 1ns/1ps

module default_slave
  import axi_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  ar_slv_t ar,
  input  logic    arvalid,
  output logic    arready,
  output r_slv_t  r,
  output logic    rvalid,
  input  logic    rready
);

  typedef enum logic {
    DS_IDLE,
    DS_RESP
  } ds_state_t;

  ds_state_t state;
  axi_ids_t  id_q;
  axi_len_t  len_q;
  axi_len_t  cnt;  // Beats already sent

  assign arready = (state == DS_IDLE);
  assign rvalid  = (state == DS_RESP);

  always_comb begin
    r.id   = id_q;
    r.data = '0;
    r.resp = RESP_DECERR;
    r.last = (cnt == len_q);
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= DS_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        DS_IDLE: begin
          if (arvalid) begin
            state <= DS_RESP;
            cnt   <= '0;
          end
        end
        default: begin
          if (rready) begin
            if (r.last) state <= DS_IDLE;
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      id_q  <= ar.id;
      len_q <= ar.len;
    end
  end

  // Counter never runs past the requested length
  a_cnt_in_len: assert property (@(posedge clk) disable iff (!rstn)
    rvalid |-> cnt <= len_q);

  // A stalled beat holds until taken
  a_beat_held: assert property (@(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> rvalid && $stable(r));

endmodule

// ==== design/ar_channel_router.sv ====
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module ar_channel_router
  import axi_pkg::*;
  import xbar_pkg::*;
(
  input  logic    clk,
  input  logic    rstn,
  input  ar_mst_t m0_ar,
  input  ar_mst_t m1_ar,
  input  logic    m0_arvalid,
  input  logic    m1_arvalid,
  output logic    m0_arready,
  output logic    m1_arready,
  output ar_slv_t s0_ar,
  output ar_slv_t s1_ar,
  output ar_slv_t sd_ar,
  output logic    s0_arvalid,
  output logic    s1_arvalid,
  output logic    sd_arvalid,
  input  logic    s0_arready,
  input  logic    s1_arready,
  input  logic    sd_arready,
  input  logic    m0_rdone,
  input  logic    m1_rdone,
  input  logic    s0_rdone,
  input  logic    s1_rdone,
  input  logic    sd_rdone
);

  arb_lock_t  arb_lock;
  arb_lock_t  arb_lock_next;
  slv_sel_t   dec;
  ar_slv_t    req;
  logic       gnt_m0;
  logic       gnt_m1;
  logic       req_valid;
  logic       sel_ready;
  logic       ar_hs;
  logic [1:0] mst_lock;  // Burst outstanding per master
  logic [2:0] slv_lock;  // Burst outstanding per slave, indexed by slv_sel_t
  logic [2:0] slv_arready;

  function automatic ar_slv_t tag_req(mst_tag_t tag, ar_mst_t ar);
    ar_slv_t t;
    t.id    = {tag, ar.id};
    t.addr  = ar.addr;
    t.len   = ar.len;
    t.size  = ar.size;
    t.burst = ar.burst;
    return t;
  endfunction

  // Fixed priority, a master with an open burst is skipped
  always_comb begin
    gnt_m0 = 1'b0;
    gnt_m1 = 1'b0;
    case (arb_lock)
      LOCK_M0: gnt_m0 = 1'b1;
      LOCK_M1: gnt_m1 = 1'b1;
      default: begin
        gnt_m0 = m0_arvalid & ~mst_lock[0];
        gnt_m1 = m1_arvalid & ~mst_lock[1] & ~gnt_m0;
      end
    endcase
  end

  assign req       = gnt_m1 ? tag_req(MST1_TAG, m1_ar) : tag_req(MST0_TAG, m0_ar);
  assign req_valid = (gnt_m0 & m0_arvalid & ~mst_lock[0]) |
                     (gnt_m1 & m1_arvalid & ~mst_lock[1]);
  assign dec       = decode_slave(req.addr);

  assign slv_arready = {sd_arready, s1_arready, s0_arready};
  assign sel_ready   = slv_arready[dec] & ~slv_lock[dec];
  assign ar_hs       = req_valid & sel_ready;

  assign s0_ar = (dec == SEL_S0) ? req : '0;
  assign s1_ar = (dec == SEL_S1) ? req : '0;
  assign sd_ar = (dec == SEL_DEF) ? req : '0;

  assign s0_arvalid = req_valid & (dec == SEL_S0) & ~slv_lock[SEL_S0];
  assign s1_arvalid = req_valid & (dec == SEL_S1) & ~slv_lock[SEL_S1];
  assign sd_arvalid = req_valid & (dec == SEL_DEF) & ~slv_lock[SEL_DEF];

  assign m0_arready = gnt_m0 & ~mst_lock[0] & sel_ready;
  assign m1_arready = gnt_m1 & ~mst_lock[1] & sel_ready;

  always_comb begin
    arb_lock_next = arb_lock;
    if (ar_hs) begin
      arb_lock_next = LOCK_FREE;
    end else if (arb_lock == LOCK_FREE) begin
      if (gnt_m0) begin
        arb_lock_next = LOCK_M0;
      end else if (gnt_m1) begin
        arb_lock_next = LOCK_M1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      arb_lock <= LOCK_FREE;
    end else begin
      arb_lock <= arb_lock_next;
    end
  end

  // Set on AR handshake, clear on the last R beat
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mst_lock <= '0;
      slv_lock <= '0;
    end else begin
      mst_lock[0] <= mst_lock[0] ? ~m0_rdone : (m0_arvalid & m0_arready);
      mst_lock[1] <= mst_lock[1] ? ~m1_rdone : (m1_arvalid & m1_arready);
      slv_lock[SEL_S0]  <= slv_lock[SEL_S0] ? ~s0_rdone : (s0_arvalid & s0_arready);
      slv_lock[SEL_S1]  <= slv_lock[SEL_S1] ? ~s1_rdone : (s1_arvalid & s1_arready);
      slv_lock[SEL_DEF] <= slv_lock[SEL_DEF] ? ~sd_rdone : (sd_arvalid & sd_arready);
    end
  end

  a_one_slave_valid: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({s0_arvalid, s1_arvalid, sd_arvalid}));

endmodule

// ==== design/xbar_pkg.sv ====
`include "axi_xbar_config.svh"

package xbar_pkg;

  import axi_pkg::*;

  // AR grant held between arbitration and slave arready
  typedef enum logic [1:0] {
    LOCK_FREE,
    LOCK_M0,
    LOCK_M1
  } arb_lock_t;

  typedef enum logic [1:0] {
    SEL_S0,
    SEL_S1,
    SEL_DEF
  } slv_sel_t;

  typedef logic [`AXI_TAG_BITS-1:0] mst_tag_t;

  localparam mst_tag_t MST0_TAG = mst_tag_t'(0);
  localparam mst_tag_t MST1_TAG = mst_tag_t'(1);

  // Offset compare, so a base of zero needs no special case
  function automatic slv_sel_t decode_slave(axi_addr_t addr);
    if ((addr - `S0_BASE) < `SLV_SPAN) begin
      return SEL_S0;
    end
    if ((addr - `S1_BASE) < `SLV_SPAN) begin
      return SEL_S1;
    end
    return SEL_DEF;
  endfunction

endpackage

// ==== design/axi_pkg.sv ====
`include "axi_xbar_config.svh"

package axi_pkg;

  typedef logic [`AXI_ID_BITS-1:0]   axi_id_t;
  typedef logic [`AXI_IDS_BITS-1:0]  axi_ids_t;  // Tag plus master ID
  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_LEN_BITS-1:0]  axi_len_t;
  typedef logic [`AXI_SIZE_BITS-1:0] axi_size_t;
  typedef logic [1:0]                axi_burst_t;
  typedef logic [1:0]                axi_resp_t;

  typedef struct packed {
    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } ar_mst_t;

  typedef struct packed {
    axi_ids_t   id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } ar_slv_t;

  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } r_mst_t;

  typedef struct packed {
    axi_ids_t  id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } r_slv_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_DECERR = 2'b11;

endpackage

// ==== design/axi_xbar_config.svh ====
`ifndef AXI_XBAR_CONFIG_SVH
`define AXI_XBAR_CONFIG_SVH

// Bus widths
`define AXI_ID_BITS    4
`define AXI_ADDR_BITS  32
`define AXI_DATA_BITS  32
`define AXI_LEN_BITS   8
`define AXI_SIZE_BITS  3

// Masters and their ID tag
`define AXI_MST_NUM    2
`define AXI_TAG_BITS   $clog2(`AXI_MST_NUM)
`define AXI_IDS_BITS   (`AXI_TAG_BITS + `AXI_ID_BITS)

// Address map, anything else goes to the default slave
`define S0_BASE        32'h0000_0000
`define S1_BASE        32'h0001_0000
`define SLV_SPAN       32'h0001_0000

`endif
